// ==== src/router_pkg.sv ====
`default_nettype none

package router_pkg;

    ////////////////////////////////////////////////////////////
    // link ports and flit geometry

    localparam int PORT_NUM      = 6;
    localparam int COORD_WIDTH   = 3;
    localparam int ADDR_WIDTH    = 3 * COORD_WIDTH;
    localparam int PAYLOAD_WIDTH = 32;
    localparam int FLIT_WIDTH    = PAYLOAD_WIDTH + 2 * ADDR_WIDTH;

    // payload at the bottom, destination z on top
    localparam int PAYLOAD_POS = 0;
    localparam int SRC_POS     = PAYLOAD_POS + PAYLOAD_WIDTH;
    localparam int DST_X_POS   = SRC_POS + ADDR_WIDTH;
    localparam int DST_Y_POS   = DST_X_POS + COORD_WIDTH;
    localparam int DST_Z_POS   = DST_Y_POS + COORD_WIDTH;

    ////////////////////////////////////////////////////////////
    // input queues

    localparam int QUEUE_DEPTH     = 8;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    typedef logic [FLIT_WIDTH-1:0]  flit_t;
    typedef logic [COORD_WIDTH-1:0] coord_t;

    // output directions, same numbering as the port arrays
    typedef enum logic [2:0] {
        DIR_XPOS = 3'd0,
        DIR_YPOS = 3'd1,
        DIR_ZPOS = 3'd2,
        DIR_XNEG = 3'd3,
        DIR_YNEG = 3'd4,
        DIR_ZNEG = 3'd5
    } dir_t;

endpackage

`default_nettype wire

// ==== src/flit_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module flit_queue (
    input  logic              clk,
    input  logic              rst,
    input  router_pkg::flit_t wr_flit,
    input  logic              wr_en,
    input  logic              pop,
    output router_pkg::flit_t head,
    output logic              head_valid
);

    import router_pkg::*;

    flit_t                      mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_PTR_WIDTH:0]   count;
    logic                       do_write;
    logic                       do_read;

    // overflow drops the incoming flit
    assign do_write = wr_en && (count != QUEUE_DEPTH[QUEUE_PTR_WIDTH:0]);
    assign do_read  = pop && head_valid;

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/route_comp.sv ====
`timescale 1ns/10ps
`default_nettype none

module route_comp #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0,
    parameter router_pkg::coord_t cur_z = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  router_pkg::flit_t head,
    input  logic              head_valid,
    input  logic              grant,
    output logic              pop,
    output logic              req,
    output router_pkg::dir_t  req_dir,
    output router_pkg::flit_t eject_flit,
    output logic              eject_valid
);

    import router_pkg::*;

    coord_t dst_x;
    coord_t dst_y;
    coord_t dst_z;
    logic   is_local;

    assign dst_x = head[DST_X_POS +: COORD_WIDTH];
    assign dst_y = head[DST_Y_POS +: COORD_WIDTH];
    assign dst_z = head[DST_Z_POS +: COORD_WIDTH];

    assign is_local = (dst_x == cur_x) && (dst_y == cur_y) && (dst_z == cur_z);

    // local heads leave at once, others wait for the switch
    assign req = head_valid && !is_local;
    assign pop = (head_valid && is_local) || grant;

    ////////////////////////////////////////////////////////////
    // dimension order, x then y then z

    always_comb begin
        if (dst_x != cur_x) begin
            req_dir = (dst_x > cur_x) ? DIR_XPOS : DIR_XNEG;
        end else if (dst_y != cur_y) begin
            req_dir = (dst_y > cur_y) ? DIR_YPOS : DIR_YNEG;
        end else begin
            req_dir = (dst_z > cur_z) ? DIR_ZPOS : DIR_ZNEG;
        end
    end

    // eject to the local kernel, one register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            eject_valid <= 1'b0;
        end else begin
            eject_valid <= head_valid && is_local;
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid && is_local) begin
            eject_flit <= head;
        end
    end

endmodule

`default_nettype wire

// ==== src/switch_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_alloc (
    input  logic              clk,
    input  logic              rst,
    input  router_pkg::flit_t head         [router_pkg::PORT_NUM],
    input  logic              req          [router_pkg::PORT_NUM],
    input  router_pkg::dir_t  req_dir      [router_pkg::PORT_NUM],
    input  router_pkg::flit_t inject_flit  [router_pkg::PORT_NUM],
    input  logic              inject_valid [router_pkg::PORT_NUM],
    output logic              grant        [router_pkg::PORT_NUM],
    output router_pkg::flit_t out_flit     [router_pkg::PORT_NUM],
    output logic              out_valid    [router_pkg::PORT_NUM]
);

    import router_pkg::*;

    typedef logic [$clog2(PORT_NUM)-1:0] port_idx_t;

    // rr_ptr[d] is the input with top priority on output d
    port_idx_t           rr_ptr [PORT_NUM];
    port_idx_t           win    [PORT_NUM];
    logic [PORT_NUM-1:0] win_ok;

    ////////////////////////////////////////////////////////////
    // round-robin search per output

    always_comb begin
        int idx;
        for (int d = 0; d < PORT_NUM; d++) begin
            win_ok[d] = 1'b0;
            win[d]    = '0;
            // walk from lowest priority up so the last hit wins
            for (int k = PORT_NUM - 1; k >= 0; k--) begin
                idx = (int'(rr_ptr[d]) + k) % PORT_NUM;
                if (req[idx] && (req_dir[idx] == dir_t'(d))) begin
                    win_ok[d] = 1'b1;
                    win[d]    = port_idx_t'(idx);
                end
            end
        end
    end

    // an input asks for one output only, so one grant at most
    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            grant[p] = req[p]
                    && win_ok[req_dir[p]]
                    && !inject_valid[req_dir[p]]
                    && (win[req_dir[p]] == port_idx_t'(p));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < PORT_NUM; d++) begin
                rr_ptr[d] <= '0;
            end
        end else begin
            for (int d = 0; d < PORT_NUM; d++) begin
                // inject holds the pointer, no winner this cycle
                if (win_ok[d] && !inject_valid[d]) begin
                    rr_ptr[d] <= (win[d] == port_idx_t'(PORT_NUM - 1)) ? '0 : win[d] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // crossbar and output registers

    always_ff @(posedge clk) begin
        for (int d = 0; d < PORT_NUM; d++) begin
            if (inject_valid[d]) begin
                out_flit[d] <= inject_flit[d];
            end else if (win_ok[d]) begin
                out_flit[d] <= head[win[d]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < PORT_NUM; d++) begin
                out_valid[d] <= 1'b0;
            end
        end else begin
            for (int d = 0; d < PORT_NUM; d++) begin
                out_valid[d] <= inject_valid[d] || win_ok[d];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/torus_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module torus_router #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0,
    parameter router_pkg::coord_t cur_z = '0
) (
    input  logic              clk,
    input  logic              rst,
    // links from the six neighbours
    input  router_pkg::flit_t in_flit      [router_pkg::PORT_NUM],
    input  logic              in_valid     [router_pkg::PORT_NUM],
    // local kernel side
    input  router_pkg::flit_t inject_flit  [router_pkg::PORT_NUM],
    input  logic              inject_valid [router_pkg::PORT_NUM],
    // links to the six neighbours
    output router_pkg::flit_t out_flit     [router_pkg::PORT_NUM],
    output logic              out_valid    [router_pkg::PORT_NUM],
    output router_pkg::flit_t eject_flit   [router_pkg::PORT_NUM],
    output logic              eject_valid  [router_pkg::PORT_NUM]
);

    import router_pkg::*;

    flit_t head       [PORT_NUM];
    logic  head_valid [PORT_NUM];
    logic  pop        [PORT_NUM];
    logic  req        [PORT_NUM];
    dir_t  req_dir    [PORT_NUM];
    logic  grant      [PORT_NUM];

    ////////////////////////////////////////////////////////////
    // per port input queue and route stage

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        flit_queue u_queue (
            .clk        (clk),
            .rst        (rst),
            .wr_flit    (in_flit[p]),
            .wr_en      (in_valid[p]),
            .pop        (pop[p]),
            .head       (head[p]),
            .head_valid (head_valid[p])
        );

        route_comp #(
            .cur_x (cur_x),
            .cur_y (cur_y),
            .cur_z (cur_z)
        ) u_route (
            .clk         (clk),
            .rst         (rst),
            .head        (head[p]),
            .head_valid  (head_valid[p]),
            .grant       (grant[p]),
            .pop         (pop[p]),
            .req         (req[p]),
            .req_dir     (req_dir[p]),
            .eject_flit  (eject_flit[p]),
            .eject_valid (eject_valid[p])
        );
    end

    ////////////////////////////////////////////////////////////
    // shared crossbar

    switch_alloc u_switch (
        .clk          (clk),
        .rst          (rst),
        .head         (head),
        .req          (req),
        .req_dir      (req_dir),
        .inject_flit  (inject_flit),
        .inject_valid (inject_valid),
        .grant        (grant),
        .out_flit     (out_flit),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== testbench/tb_torus_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_torus_router;

    import router_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int LOCAL_DIR  = PORT_NUM;
    localparam coord_t NODE_X = 3'd3;
    localparam coord_t NODE_Y = 3'd3;
    localparam coord_t NODE_Z = 3'd3;
    localparam int N_ROUTE    = 24;
    localparam int N_PER      = 4;
    localparam int TOTAL_FLITS = PORT_NUM + N_ROUTE + 2 * PORT_NUM + PORT_NUM * N_PER;

    logic  clk;
    logic  rst;
    flit_t in_flit      [PORT_NUM];
    logic  in_valid     [PORT_NUM];
    flit_t inject_flit  [PORT_NUM];
    logic  inject_valid [PORT_NUM];
    flit_t out_flit     [PORT_NUM];
    logic  out_valid    [PORT_NUM];
    flit_t eject_flit   [PORT_NUM];
    logic  eject_valid  [PORT_NUM];

    // slots 0..5 are output links and 6..11 eject ports
    flit_t       exp_q [2 * PORT_NUM][$];
    int          errors;
    int          checks;
    int          tests_done;
    logic        cmp_en;
    int unsigned rng_state;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    torus_router #(
        .cur_x (NODE_X),
        .cur_y (NODE_Y),
        .cur_z (NODE_Z)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .inject_flit  (inject_flit),
        .inject_valid (inject_valid),
        .out_flit     (out_flit),
        .out_valid    (out_valid),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid)
    );

    ////////////////////////////////////////////////////////////
    // helpers

    function automatic int unsigned rand_below(int unsigned n);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return (rng_state >> 16) % n;
    endfunction

    function automatic flit_t make_flit(coord_t x, coord_t y, coord_t z,
                                        logic [ADDR_WIDTH-1:0] src,
                                        logic [PAYLOAD_WIDTH-1:0] payload);
        flit_t f;
        f = '0;
        f[DST_X_POS +: COORD_WIDTH]     = x;
        f[DST_Y_POS +: COORD_WIDTH]     = y;
        f[DST_Z_POS +: COORD_WIDTH]     = z;
        f[SRC_POS +: ADDR_WIDTH]        = src;
        f[PAYLOAD_POS +: PAYLOAD_WIDTH] = payload;
        return f;
    endfunction

    function automatic logic [PAYLOAD_WIDTH-1:0] rand_payload();
        return {16'(rand_below(65536)), 16'(rand_below(65536))};
    endfunction

    // x first, then y, then z, with the sign picking pos or neg
    function automatic int expected_dir(flit_t f);
        coord_t x;
        coord_t y;
        coord_t z;
        x = f[DST_X_POS +: COORD_WIDTH];
        y = f[DST_Y_POS +: COORD_WIDTH];
        z = f[DST_Z_POS +: COORD_WIDTH];
        if (x != NODE_X) return (x > NODE_X) ? int'(DIR_XPOS) : int'(DIR_XNEG);
        if (y != NODE_Y) return (y > NODE_Y) ? int'(DIR_YPOS) : int'(DIR_YNEG);
        if (z != NODE_Z) return (z > NODE_Z) ? int'(DIR_ZPOS) : int'(DIR_ZNEG);
        return LOCAL_DIR;
    endfunction

    // random destination that leaves through output d
    task automatic pick_toward(int d, output coord_t x, output coord_t y, output coord_t z);
        coord_t up;
        coord_t down;
        up   = coord_t'(4 + rand_below(4));
        down = coord_t'(rand_below(3));
        x = coord_t'(rand_below(8));
        y = coord_t'(rand_below(8));
        z = coord_t'(rand_below(8));
        case (dir_t'(d))
            DIR_XPOS: x = up;
            DIR_XNEG: x = down;
            DIR_YPOS: begin
                x = NODE_X;
                y = up;
            end
            DIR_YNEG: begin
                x = NODE_X;
                y = down;
            end
            DIR_ZPOS: begin
                x = NODE_X;
                y = NODE_Y;
                z = up;
            end
            default: begin
                x = NODE_X;
                y = NODE_Y;
                z = down;
            end
        endcase
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // takes the first pending flit of the same source so per-source order counts
    task automatic match_flit(int slot, flit_t got, string name);
        int found;
        found = -1;
        for (int i = 0; i < exp_q[slot].size(); i++) begin
            if (found < 0 && exp_q[slot][i][SRC_POS +: ADDR_WIDTH] == got[SRC_POS +: ADDR_WIDTH])
                found = i;
        end
        if (exp_q[slot].size() == 0) begin
            $display("%s delivered a flit (0x%h) while none was expected", name, got);
            errors++;
        end else begin
            if (found < 0) found = 0;
            check_value(name, 64'(got), 64'(exp_q[slot][found]));
            exp_q[slot].delete(found);
        end
    endtask

    task automatic drive_link(int p, flit_t f);
        int d;
        in_flit[p]  = f;
        in_valid[p] = 1'b1;
        d = expected_dir(f);
        if (d == LOCAL_DIR) exp_q[PORT_NUM + p].push_back(f);
        else exp_q[d].push_back(f);
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        for (int p = 0; p < PORT_NUM; p++) begin
            in_valid[p]     = 1'b0;
            inject_valid[p] = 1'b0;
        end
    endtask

    function automatic bit all_drained();
        for (int i = 0; i < 2 * PORT_NUM; i++) begin
            if (exp_q[i].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_drain(int max_cycles, string what);
        int n;
        n = 0;
        while (!all_drained() && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!all_drained()) begin
            $display("%s: expected flits still missing after %0d cycles", what, max_cycles);
            errors++;
            for (int i = 0; i < 2 * PORT_NUM; i++) exp_q[i].delete();
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests_done++;
        $display("test %-10s finished, %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////////////////////////
    // compare process

    always @(posedge clk) begin
        if (cmp_en) begin
            for (int d = 0; d < PORT_NUM; d++) begin
                if (out_valid[d]) match_flit(d, out_flit[d], $sformatf("out_flit[%0d]", d));
                if (eject_valid[d])
                    match_flit(PORT_NUM + d, eject_flit[d], $sformatf("eject_flit[%0d]", d));
            end
        end
    end

    // watchdog
    initial begin
        #(TOTAL_FLITS * 20 * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TOTAL_FLITS * 20);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int     err0;
        int     p;
        coord_t x;
        coord_t y;
        coord_t z;
        flit_t  f;
        flit_t  g;

        rst = 1'b1;
        cmp_en = 1'b0;
        errors = 0;
        checks = 0;
        tests_done = 0;
        rng_state = 95;
        for (int i = 0; i < PORT_NUM; i++) begin
            in_flit[i]      = '0;
            in_valid[i]     = 1'b0;
            inject_flit[i]  = '0;
            inject_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cmp_en = 1'b1;

        err0 = errors;
        repeat (4) begin
            @(negedge clk);
            for (int d = 0; d < PORT_NUM; d++) begin
                check_value($sformatf("out_valid[%0d]", d), 64'(out_valid[d]), 64'd0);
                check_value($sformatf("eject_valid[%0d]", d), 64'(eject_valid[d]), 64'd0);
            end
        end
        report_test("reset", err0);

        // local flits on all six inputs in the same cycle
        err0 = errors;
        for (int i = 0; i < PORT_NUM; i++)
            drive_link(i, make_flit(NODE_X, NODE_Y, NODE_Z, ADDR_WIDTH'(rand_below(512)),
                                    rand_payload()));
        advance_cycle();
        wait_drain(2, "eject");
        report_test("eject", err0);

        err0 = errors;
        for (int n = 0; n < N_ROUTE; n++) begin
            p = int'(rand_below(PORT_NUM));
            f = make_flit(coord_t'(rand_below(8)), coord_t'(rand_below(8)),
                          coord_t'(rand_below(8)), ADDR_WIDTH'(rand_below(512)), rand_payload());
            drive_link(p, f);
            advance_cycle();
            wait_drain(2, "routing");
        end
        report_test("routing", err0);

        // inject lands while the switched head is requesting the same output
        err0 = errors;
        for (int d = 0; d < PORT_NUM; d++) begin
            p = int'(rand_below(PORT_NUM));
            pick_toward(d, x, y, z);
            f = make_flit(x, y, z, ADDR_WIDTH'(p), rand_payload());
            g = make_flit(coord_t'(rand_below(8)), coord_t'(rand_below(8)),
                          coord_t'(rand_below(8)), 9'h1ff, rand_payload());
            drive_link(p, f);
            advance_cycle();
            inject_flit[d]  = g;
            inject_valid[d] = 1'b1;
            exp_q[d].push_back(g);
            advance_cycle();
            @(negedge clk);
            check_value($sformatf("pending on out_flit[%0d]", d), 64'(exp_q[d].size()), 64'd1);
            if (exp_q[d].size() == 1)
                check_value($sformatf("held flit for out_flit[%0d]", d),
                            64'(exp_q[d][0]), 64'(f));
            wait_drain(1, "inject");
        end
        report_test("inject", err0);

        err0 = errors;
        for (int k = 0; k < N_PER; k++) begin
            for (int i = 0; i < PORT_NUM; i++) begin
                pick_toward(int'(DIR_YNEG), x, y, z);
                f = make_flit(x, y, z, ADDR_WIDTH'(i), {16'(k), 16'(rand_below(65536))});
                drive_link(i, f);
            end
            advance_cycle();
        end
        wait_drain(PORT_NUM * N_PER + 4, "contention");
        // idle cycles so a late or duplicated flit still reaches the compare
        repeat (4) @(negedge clk);
        report_test("contention", err0);

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== torus_router.f ====
src/router_pkg.sv
src/flit_queue.sv
src/route_comp.sv
src/switch_alloc.sv
src/torus_router.sv
testbench/tb_clock.sv
testbench/tb_torus_router.sv

// ==== Makefile ====
# Verilator build and run for the torus router testbench

VERILATOR  ?= verilator
TOP        ?= tb_torus_router
FILELIST   ?= torus_router.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
